//--- verilog/ahb_config.svh
// Subsystem build-time sizes
// Slave count, memory map match values, RAM depth, PWM counter width
`ifndef AHB_CONFIG_SVH
`define AHB_CONFIG_SVH

// RAM, GPIO and PWM slaves on the shared bus
`define AHB_SLAVE_COUNT     3

// Match values for haddr[31:16]
`define AHB_RAM_MATCH       16'h0000    // RAM window
`define AHB_GPIO_MATCH      16'h0001    // GPIO window
`define AHB_PWM_MATCH       16'h0002    // PWM window

// Word RAM depth
`define AHB_RAM_WORDS       256

// PWM counter, period and duty width
`define AHB_PWM_WIDTH       8

`endif

//--- verilog/ahb_pkg.sv
// AHB-Lite bus protocol types
// Address and data words, transfer and response encodings, select vector, FSM and owner types
`include "ahb_config.svh"

package ahb_pkg;

    typedef logic [31:0] haddr_t;                   // Byte address
    typedef logic [31:0] hdata_t;                   // Read/write data word

    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        BUSY   = 2'b01,                             // Handled as IDLE
        NONSEQ = 2'b10,
        SEQ    = 2'b11                              // Handled as NONSEQ
    } htrans_t;

    typedef enum logic [1:0]
    {
        OKAY  = 2'b00,
        ERROR = 2'b01,
        RETRY = 2'b10,                              // Never issued here
        SPLIT = 2'b11                               // Never issued here
    } hresp_t;

    typedef logic [2:0] hsize_t;                    // Carried but not decoded
    typedef logic [2:0] hburst_t;                   // Carried but not decoded

    typedef logic [`AHB_SLAVE_COUNT-1:0] hsel_t;    // One-hot slave select

    // Two-cycle ERROR response of the router
    typedef enum logic [1:0]
    {
        ERR_IDLE   = 2'b00,
        ERR_FIRST  = 2'b01,                         // hready low
        ERR_SECOND = 2'b10                          // hready high
    } err_state_t;

    typedef logic [0:0] owner_t;                    // Master index

endpackage : ahb_pkg

//--- verilog/periph_pkg.sv
// Peripheral-side types
// RAM word index, GPIO word, PWM count and PWM register offsets
`include "ahb_config.svh"

package periph_pkg;

    typedef logic [$clog2(`AHB_RAM_WORDS)-1:0] ram_index_t;    // From haddr[9:2]

    typedef logic [31:0] gpio_word_t;                          // Pin word

    typedef logic [`AHB_PWM_WIDTH-1:0] pwm_cnt_t;              // Counter, period, duty

    // Byte offsets inside the PWM window
    typedef enum logic [2:0]
    {
        PWM_PERIOD = 3'd0,
        PWM_DUTY   = 3'd4
    } pwm_reg_t;

endpackage : periph_pkg

//--- verilog/ahb_if.sv
// AHB-Lite bus bundle
// Master, slave and router modports
`timescale 1ns/1ps

interface ahb_if;
    import ahb_pkg::*;

    haddr_t  haddr;     // Address phase
    hdata_t  hwdata;    // Data phase, master to slave
    hdata_t  hrdata;    // Data phase, slave to master
    logic    hwrite;
    htrans_t htrans;
    hsize_t  hsize;
    hburst_t hburst;
    hresp_t  hresp;
    logic    hready;    // Master side only as slave ready is fixed in the router
    logic    hsel;      // Slave select or master-side decode hit

    // Arbiter output side and the router's drive onto each slave
    modport master
    (
        output haddr, hwdata, hwrite, htrans, hsize, hburst, hsel,
        input  hrdata, hresp, hready
    );

    // Zero-wait slaves that always answer OKAY
    modport slave
    (
        input  haddr, hwdata, hwrite, htrans, hsize, hburst, hsel,
        output hrdata, hresp
    );

    // Router view of the master-side bus
    modport router
    (
        input  haddr, hwdata, hwrite, htrans, hsize, hburst,
        output hrdata, hresp, hready, hsel
    );

endinterface : ahb_if

//--- verilog/ahb_arbiter.sv
// Two-master round-robin arbiter
// Owner registers, grant levels and address/data-phase bus multiplexer
`timescale 1ns/1ps

module ahb_arbiter
(
    input  logic             hclk,
    input  logic             arst_n,
    input  logic             m0_hbusreq,    // Request levels
    input  logic             m1_hbusreq,
    output logic             m0_hgrant,     // Grant levels
    output logic             m1_hgrant,
    input  ahb_pkg::haddr_t  m0_haddr,
    input  ahb_pkg::haddr_t  m1_haddr,
    input  ahb_pkg::htrans_t m0_htrans,
    input  ahb_pkg::htrans_t m1_htrans,
    input  logic             m0_hwrite,
    input  logic             m1_hwrite,
    input  ahb_pkg::hsize_t  m0_hsize,
    input  ahb_pkg::hsize_t  m1_hsize,
    input  ahb_pkg::hburst_t m0_hburst,
    input  ahb_pkg::hburst_t m1_hburst,
    input  ahb_pkg::hdata_t  m0_hwdata,
    input  ahb_pkg::hdata_t  m1_hwdata,
    ahb_if.master            bus            // Shared bus toward the router
);
    import ahb_pkg::*;

    owner_t  owner;         // Address-phase owner
    owner_t  data_owner;    // Owner of the last accepted address phase
    owner_t  other;
    logic    other_req;
    logic    cur_req;
    logic    cur_active;    // Owner drives NONSEQ/SEQ
    htrans_t cur_trans;

    assign other      = ~owner;
    assign other_req  = other[0] ? m1_hbusreq : m0_hbusreq;
    assign cur_req    = owner[0] ? m1_hbusreq : m0_hbusreq;
    assign cur_trans  = owner[0] ? m1_htrans : m0_htrans;
    assign cur_active = (cur_trans == NONSEQ) || (cur_trans == SEQ);

    assign m0_hgrant = !owner[0];
    assign m1_hgrant = owner[0];

    always_ff @(posedge hclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            owner      <= '0;                   // Master 0 after reset
            data_owner <= '0;
        end
        else if (bus.hready)                    // Frozen during error stall
        begin
            data_owner <= owner;
            if (other_req && (!cur_req || cur_active))
                owner <= other;                 // Hand over to waiting master
        end
    end

    // Address and control from the owner only
    assign bus.haddr  = owner[0] ? m1_haddr : m0_haddr;
    assign bus.htrans = cur_trans;
    assign bus.hwrite = owner[0] ? m1_hwrite : m0_hwrite;
    assign bus.hsize  = owner[0] ? m1_hsize : m0_hsize;
    assign bus.hburst = owner[0] ? m1_hburst : m0_hburst;
    assign bus.hwdata = data_owner[0] ? m1_hwdata : m0_hwdata;    // Lags one phase

    grant_exclusive : assert property (@(posedge hclk) disable iff (!arst_n)
        !(m0_hgrant && m1_hgrant));

    // Stalled transfer keeps its master on the bus
    owner_held : assert property (@(posedge hclk) disable iff (!arst_n)
        !bus.hready |=> $stable(owner));

endmodule : ahb_arbiter

//--- verilog/ahb_router.sv
// AHB router with address decoder and data-phase select register
// Response multiplexer and two-cycle ERROR responder for unmapped addresses
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahb_router
#(
    parameter int slave_c = `AHB_SLAVE_COUNT
)(
    input logic   hclk,
    input logic   arst_n,
    ahb_if.router bus,                  // Master side from the arbiter
    ahb_if.master bus_s [slave_c]       // One bus per slave
);
    import ahb_pkg::*;

    // Memory map with the RAM at index 0
    localparam logic [slave_c-1:0][15:0] match_vec =
    {
        `AHB_PWM_MATCH,
        `AHB_GPIO_MATCH,
        `AHB_RAM_MATCH
    };

    hsel_t      hsel_dec;               // Address-phase select
    hsel_t      hsel_ff;                // Data-phase select
    logic       addr_valid;
    logic       miss_start;             // Accepted NONSEQ to no slave
    err_state_t err_state;
    err_state_t err_next;
    hdata_t     rdata_s [slave_c];
    hresp_t     resp_s  [slave_c];

    always_comb
    begin
        for (int i = 0; i < slave_c; i++)
            hsel_dec[i] = (bus.haddr[31:16] == match_vec[i]);
    end

    assign bus.hsel   = |hsel_dec;
    assign addr_valid = (bus.htrans == NONSEQ) || (bus.htrans == SEQ);
    assign miss_start = bus.hready && addr_valid && !bus.hsel;

    for (genvar i = 0; i < slave_c; i++)
    begin : gen_slave
        assign bus_s[i].haddr  = bus.haddr;
        assign bus_s[i].hwdata = bus.hwdata;
        assign bus_s[i].hwrite = bus.hwrite;
        assign bus_s[i].htrans = bus.htrans;
        assign bus_s[i].hsize  = bus.hsize;
        assign bus_s[i].hburst = bus.hburst;
        assign bus_s[i].hsel   = hsel_dec[i] && bus.hready;    // Slaves ignore stalled phases
        assign rdata_s[i]      = bus_s[i].hrdata;
        assign resp_s[i]       = bus_s[i].hresp;
    end

    // Second error cycle may itself accept a new miss
    assign err_next = (err_state == ERR_FIRST) ? ERR_SECOND :
                      (miss_start ? ERR_FIRST : ERR_IDLE);

    always_ff @(posedge hclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            err_state <= ERR_IDLE;
            hsel_ff   <= '0;
        end
        else
        begin
            err_state <= err_next;
            if (bus.hready)
                hsel_ff <= addr_valid ? hsel_dec : '0;
        end
    end

    always_comb
    begin
        bus.hrdata = '0;
        bus.hresp  = OKAY;
        for (int i = 0; i < slave_c; i++)
        begin
            if (hsel_ff[i])
            begin
                bus.hrdata = rdata_s[i];
                bus.hresp  = resp_s[i];
            end
        end
        if (err_state != ERR_IDLE)
            bus.hresp = ERROR;          // Both error cycles
    end

    assign bus.hready = (err_state != ERR_FIRST);   // Only stall source

    sel_onehot : assert property (@(posedge hclk) disable iff (!arst_n)
        $onehot0(hsel_ff));

endmodule : ahb_router

//--- verilog/ahb_ram.sv
// Zero-wait word RAM slave
// Address-phase capture, data-phase write, registered read with write bypass
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahb_ram
(
    input logic  hclk,
    input logic  arst_n,
    ahb_if.slave bus
);
    import ahb_pkg::*;
    import periph_pkg::*;

    hdata_t     mem [`AHB_RAM_WORDS];
    hdata_t     rdata_ff;               // Read word for the data phase
    ram_index_t idx;
    ram_index_t idx_ff;                 // Index of the pending transfer
    logic       sel_valid;
    logic       wr_ff;                  // Write in data phase

    assign idx       = bus.haddr[9:2];
    assign sel_valid = bus.hsel && ((bus.htrans == NONSEQ) || (bus.htrans == SEQ));

    always_ff @(posedge hclk or negedge arst_n)
    begin
        if (!arst_n)
            wr_ff <= 1'b0;
        else
            wr_ff <= sel_valid && bus.hwrite;
    end

    always_ff @(posedge hclk)
    begin
        if (wr_ff)
            mem[idx_ff] <= bus.hwdata;
        if (sel_valid)
        begin
            idx_ff <= idx;
            // Read right behind a write to the same word
            if (wr_ff && (idx_ff == idx))
                rdata_ff <= bus.hwdata;
            else
                rdata_ff <= mem[idx];
        end
    end

    assign bus.hrdata = rdata_ff;
    assign bus.hresp  = OKAY;

endmodule : ahb_ram

//--- verilog/ahb_gpio.sv
// GPIO slave
// Output register at offset 0, synchronized input readback at offset 4
`timescale 1ns/1ps

module ahb_gpio
(
    input  logic                   hclk,
    input  logic                   arst_n,
    ahb_if.slave                   bus,
    input  periph_pkg::gpio_word_t gpio_in,     // Asynchronous pins
    output periph_pkg::gpio_word_t gpio_out
);
    import ahb_pkg::*;
    import periph_pkg::*;

    gpio_word_t in_meta;                // First sync stage
    gpio_word_t in_sync;                // Second sync stage
    logic       sel_valid;
    logic       wr_ff;
    logic       off_ff;                 // haddr[2] of the pending transfer

    assign sel_valid = bus.hsel && ((bus.htrans == NONSEQ) || (bus.htrans == SEQ));

    always_ff @(posedge hclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ff    <= 1'b0;
            gpio_out <= '0;
            in_meta  <= '0;
            in_sync  <= '0;
        end
        else
        begin
            wr_ff   <= sel_valid && bus.hwrite;
            in_meta <= gpio_in;
            in_sync <= in_meta;
            if (wr_ff && !off_ff)
                gpio_out <= bus.hwdata;     // Offset 4 is read-only
        end
    end

    always_ff @(posedge hclk)
    begin
        if (sel_valid)
            off_ff <= bus.haddr[2];
    end

    assign bus.hrdata = off_ff ? in_sync : gpio_out;
    assign bus.hresp  = OKAY;

endmodule : ahb_gpio

//--- verilog/ahb_pwm.sv
// PWM slave
// Staged and active period/duty registers, wrap counter and duty compare
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahb_pwm
(
    input  logic hclk,
    input  logic arst_n,
    ahb_if.slave bus,
    output logic pwm_out
);
    import ahb_pkg::*;
    import periph_pkg::*;

    pwm_cnt_t cnt;                      // Runs 0 .. period_act
    pwm_cnt_t period_stg;               // Bus-visible values
    pwm_cnt_t duty_stg;
    pwm_cnt_t period_act;               // Loaded at wrap
    pwm_cnt_t duty_act;
    pwm_cnt_t rd_val;
    pwm_reg_t reg_ff;                   // Register of the pending transfer
    logic     sel_valid;
    logic     wr_ff;
    logic     wrap;

    assign sel_valid = bus.hsel && ((bus.htrans == NONSEQ) || (bus.htrans == SEQ));
    assign wrap      = (cnt == period_act);

    always_ff @(posedge hclk)
    begin
        if (sel_valid)
            reg_ff <= bus.haddr[2] ? PWM_DUTY : PWM_PERIOD;
    end

    always_ff @(posedge hclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ff      <= 1'b0;
            period_stg <= '0;
            duty_stg   <= '0;
            period_act <= '0;
            duty_act   <= '0;
            cnt        <= '0;
        end
        else
        begin
            wr_ff <= sel_valid && bus.hwrite;
            if (wr_ff && (reg_ff == PWM_PERIOD))
                period_stg <= bus.hwdata[`AHB_PWM_WIDTH-1:0];
            if (wr_ff && (reg_ff == PWM_DUTY))
                duty_stg <= bus.hwdata[`AHB_PWM_WIDTH-1:0];
            if (wrap)
            begin
                cnt        <= '0;
                period_act <= period_stg;   // New settings start a fresh period
                duty_act   <= duty_stg;
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    assign rd_val     = (reg_ff == PWM_DUTY) ? duty_stg : period_stg;
    assign bus.hrdata = {{(32-`AHB_PWM_WIDTH){1'b0}}, rd_val};
    assign bus.hresp  = OKAY;

    assign pwm_out = (cnt < duty_act);  // Duty above period gives constant high

    duty_zero_low : assert property (@(posedge hclk) disable iff (!arst_n)
        (duty_act == '0) |-> !pwm_out);

endmodule : ahb_pwm

//--- verilog/ahb_subsys_top.sv
// AHB-Lite subsystem top level
// Two master ports, arbiter, router, RAM, GPIO and PWM slaves
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahb_subsys_top
(
    input  logic                   hclk,
    input  logic                   arst_n,
    // Master 0
    input  logic                   m0_hbusreq,
    output logic                   m0_hgrant,
    input  ahb_pkg::haddr_t        m0_haddr,
    input  logic                   m0_hwrite,
    input  ahb_pkg::htrans_t       m0_htrans,
    input  ahb_pkg::hsize_t        m0_hsize,
    input  ahb_pkg::hburst_t       m0_hburst,
    input  ahb_pkg::hdata_t        m0_hwdata,
    // Master 1
    input  logic                   m1_hbusreq,
    output logic                   m1_hgrant,
    input  ahb_pkg::haddr_t        m1_haddr,
    input  logic                   m1_hwrite,
    input  ahb_pkg::htrans_t       m1_htrans,
    input  ahb_pkg::hsize_t        m1_hsize,
    input  ahb_pkg::hburst_t       m1_hburst,
    input  ahb_pkg::hdata_t        m1_hwdata,
    // Shared response
    output ahb_pkg::hdata_t        hrdata,
    output ahb_pkg::hresp_t        hresp,
    output logic                   hready,
    // Peripheral pins
    input  periph_pkg::gpio_word_t gpio_in,
    output periph_pkg::gpio_word_t gpio_out,
    output logic                   pwm_out
);

    ahb_if bus_m ();                            // Arbiter to router
    ahb_if bus_s [`AHB_SLAVE_COUNT] ();         // Router to slaves

    assign hrdata = bus_m.hrdata;
    assign hresp  = bus_m.hresp;
    assign hready = bus_m.hready;

    ahb_arbiter u_arbiter
    (
        .hclk       ( hclk       ),
        .arst_n     ( arst_n     ),
        .m0_hbusreq ( m0_hbusreq ),
        .m1_hbusreq ( m1_hbusreq ),
        .m0_hgrant  ( m0_hgrant  ),
        .m1_hgrant  ( m1_hgrant  ),
        .m0_haddr   ( m0_haddr   ),
        .m1_haddr   ( m1_haddr   ),
        .m0_htrans  ( m0_htrans  ),
        .m1_htrans  ( m1_htrans  ),
        .m0_hwrite  ( m0_hwrite  ),
        .m1_hwrite  ( m1_hwrite  ),
        .m0_hsize   ( m0_hsize   ),
        .m1_hsize   ( m1_hsize   ),
        .m0_hburst  ( m0_hburst  ),
        .m1_hburst  ( m1_hburst  ),
        .m0_hwdata  ( m0_hwdata  ),
        .m1_hwdata  ( m1_hwdata  ),
        .bus        ( bus_m      )
    );

    ahb_router #(.slave_c(`AHB_SLAVE_COUNT)) u_router
    (
        .hclk   ( hclk   ),
        .arst_n ( arst_n ),
        .bus    ( bus_m  ),
        .bus_s  ( bus_s  )
    );

    ahb_ram u_ram (.hclk(hclk), .arst_n(arst_n), .bus(bus_s[0]));     // 0x0000_xxxx

    ahb_gpio u_gpio                                                     // 0x0001_xxxx
    (
        .hclk     ( hclk     ),
        .arst_n   ( arst_n   ),
        .bus      ( bus_s[1] ),
        .gpio_in  ( gpio_in  ),
        .gpio_out ( gpio_out )
    );

    ahb_pwm u_pwm                                                       // 0x0002_xxxx
    (
        .hclk    ( hclk     ),
        .arst_n  ( arst_n   ),
        .bus     ( bus_s[2] ),
        .pwm_out ( pwm_out  )
    );

endmodule : ahb_subsys_top

//--- dv/tb_ahb_subsys.sv
// Testbench for the AHB-Lite subsystem
// LFSR stimulus, bus-level model, compare tasks and watchdog
`timescale 1ns/1ps
`include "ahb_config.svh"

module tb_ahb_subsys;
    import ahb_pkg::*;
    import periph_pkg::*;

    localparam int ram_n_c  = 64;                   // Write/read pairs
    localparam int gpio_n_c = 8;
    localparam int err_n_c  = 4;
    localparam int arb_n_c  = 8;                    // Writes per master
    localparam int pwm_n_c  = 2;
    localparam int xfer_n_c = 2*ram_n_c + 2*gpio_n_c + 1 + 2*err_n_c + 4*arb_n_c + 4*pwm_n_c;
    localparam int pwm_win_c = pwm_n_c * (3 * (1 << `AHB_PWM_WIDTH) + 2);
    localparam int limit_c  = xfer_n_c*4 + pwm_win_c + 500;    // In clock cycles

    logic       hclk;
    logic       arst_n;
    logic [1:0] m_hbusreq;
    logic [1:0] m_hgrant;
    logic [1:0] m_hwrite;
    haddr_t     m_haddr  [2];
    htrans_t    m_htrans [2];
    hsize_t     m_hsize  [2];
    hburst_t    m_hburst [2];
    hdata_t     m_hwdata [2];
    hdata_t     hrdata;
    hresp_t     hresp;
    logic       hready;
    gpio_word_t gpio_in;
    gpio_word_t gpio_out;
    logic       pwm_out;

    logic [31:0] lfsr;
    hdata_t      ram_m [`AHB_RAM_WORDS];            // RAM model
    logic        ram_v [`AHB_RAM_WORDS];            // Word written at least once
    gpio_word_t  gpio_m;
    pwm_cnt_t    period_stg_m;
    pwm_cnt_t    duty_stg_m;
    pwm_cnt_t    period_act_m;
    pwm_cnt_t    duty_act_m;
    ram_index_t  arb_idx [2][arb_n_c];
    hdata_t      arb_dat [2][arb_n_c];
    logic        keep_req;                          // Hold hbusreq between transfers
    logic        accepted [$];                      // Master of each accepted address phase
    string       cur_test;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;

    ahb_subsys_top DUT
    (
        .hclk       ( hclk         ),
        .arst_n     ( arst_n       ),
        .m0_hbusreq ( m_hbusreq[0] ),
        .m0_hgrant  ( m_hgrant[0]  ),
        .m0_haddr   ( m_haddr[0]   ),
        .m0_hwrite  ( m_hwrite[0]  ),
        .m0_htrans  ( m_htrans[0]  ),
        .m0_hsize   ( m_hsize[0]   ),
        .m0_hburst  ( m_hburst[0]  ),
        .m0_hwdata  ( m_hwdata[0]  ),
        .m1_hbusreq ( m_hbusreq[1] ),
        .m1_hgrant  ( m_hgrant[1]  ),
        .m1_haddr   ( m_haddr[1]   ),
        .m1_hwrite  ( m_hwrite[1]  ),
        .m1_htrans  ( m_htrans[1]  ),
        .m1_hsize   ( m_hsize[1]   ),
        .m1_hburst  ( m_hburst[1]  ),
        .m1_hwdata  ( m_hwdata[1]  ),
        .hrdata     ( hrdata       ),
        .hresp      ( hresp        ),
        .hready     ( hready       ),
        .gpio_in    ( gpio_in      ),
        .gpio_out   ( gpio_out     ),
        .pwm_out    ( pwm_out      )
    );

    always #4 hclk = ~hclk;                         // 8 ns period

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic haddr_t ram_addr(input ram_index_t idx);
        logic [5:0] hi;
        hi = 6'(rand_bits(6));                      // Bits 15:10 are don't care
        return {`AHB_RAM_MATCH, hi, idx, 2'b00};
    endfunction

    task automatic check_data(input string what, input hdata_t exp, input hdata_t act);
        if (act !== exp)
        begin
            $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_resp(input string what, input hresp_t exp, input hresp_t act);
        if (act !== exp)
        begin
            $display("** Error %s %s: expected %s, actual %s", cur_test, what,
                     exp.name(), act.name());
            test_errs++;
        end
    endtask

    task automatic check_gpio(input string what, input gpio_word_t exp, input gpio_word_t act);
        if (act !== exp)
        begin
            $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic end_test();
        if (test_errs == 0)
        begin
            $display("PASS  %s", cur_test);
            tests_ok++;
        end
        else
        begin
            $display("FAIL  %s, %0d mismatches", cur_test, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    // Request, grant, address and data phase with rdy1/resp1 from the first data cycle
    task automatic bus_xfer(input logic m, input logic wr, input haddr_t addr,
                            input hdata_t wdata, output hdata_t rdata, output hresp_t resp,
                            output logic rdy1, output hresp_t resp1);
        @(negedge hclk);
        m_hbusreq[m] = 1'b1;
        while (!(m_hgrant[m] && hready))
            @(negedge hclk);
        m_haddr[m]  = addr;
        m_hwrite[m] = wr;
        m_htrans[m] = NONSEQ;                       // Accepted at the next rising edge
        @(negedge hclk);
        m_hbusreq[m] = keep_req;
        m_htrans[m]  = IDLE;
        m_hwdata[m]  = wdata;
        accepted.push_back(m);
        rdy1  = hready;
        resp1 = hresp;
        if (!hready)                                // Error stall lasts one cycle
            @(negedge hclk);
        rdata = hrdata;
        resp  = hresp;
    endtask

    task automatic bus_write(input logic m, input haddr_t addr, input hdata_t data);
        hdata_t rd;
        hresp_t rs;
        hresp_t rs1;
        logic   rdy1;
        bus_xfer(m, 1'b1, addr, data, rd, rs, rdy1, rs1);
        check_bit("write ready", 1'b1, rdy1);
        check_resp("write response", OKAY, rs);
    endtask

    task automatic bus_read(input logic m, input haddr_t addr, output hdata_t data);
        hresp_t rs;
        hresp_t rs1;
        logic   rdy1;
        bus_xfer(m, 1'b0, addr, '0, data, rs, rdy1, rs1);
        check_bit("read ready", 1'b1, rdy1);
        check_resp("read response", OKAY, rs);
    endtask

    // One master of the arbitration test with its request held throughout
    task automatic arb_master(input logic m);
        for (int i = 0; i < arb_n_c; i++)
        begin
            bus_write(m, {`AHB_RAM_MATCH, 6'd0, arb_idx[m][i], 2'b00}, arb_dat[m][i]);
            check_bit("grant handover", 1'b1, m_hgrant[!m]);
            ram_m[arb_idx[m][i]] = arb_dat[m][i];
            ram_v[arb_idx[m][i]] = 1'b1;
        end
    endtask

    initial
    begin
        #(limit_c * 8);
        $display("Watchdog: run did not finish within %0d clock cycles", limit_c);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        logic       m;
        logic       rdy1;
        logic [15:0] upper;
        logic [13:0] lo;
        ram_index_t idx;
        ram_index_t ridx;
        hdata_t     data;
        hdata_t     rd;
        hresp_t     rs;
        hresp_t     rs1;
        int         cnt;
        int         pp;
        int         dd;

        hclk      = 1'b0;
        arst_n    = 1'b0;
        m_hbusreq = '0;
        m_hwrite  = '0;
        gpio_in   = '0;
        keep_req  = 1'b0;
        lfsr      = 32'h7c36738a;
        test_errs = 0;
        tests_ok  = 0;
        tests_bad = 0;
        gpio_m    = '0;
        for (int k = 0; k < 2; k++)
        begin
            m_haddr[k]  = '0;
            m_htrans[k] = IDLE;
            m_hsize[k]  = 3'b010;                   // Word
            m_hburst[k] = 3'b000;                   // Single
            m_hwdata[k] = '0;
        end
        for (int i = 0; i < `AHB_RAM_WORDS; i++)
            ram_v[i] = 1'b0;
        repeat (8) @(posedge hclk);
        @(negedge hclk);
        arst_n = 1'b1;

        cur_test = "reset";
        @(negedge hclk);
        check_bit("hready", 1'b1, hready);
        check_resp("hresp", OKAY, hresp);
        check_gpio("gpio_out", '0, gpio_out);
        check_bit("pwm_out", 1'b0, pwm_out);
        check_bit("m0_hgrant", 1'b1, m_hgrant[0]);
        check_bit("m1_hgrant", 1'b0, m_hgrant[1]);
        end_test();

        cur_test = "ram";
        idx = '0;
        for (int i = 0; i < ram_n_c; i++)
        begin
            m    = 1'(rand_bits(1));
            idx  = ram_index_t'(rand_bits(8));
            data = rand_bits(32);
            bus_write(m, ram_addr(idx), data);
            ram_m[idx] = data;
            ram_v[idx] = 1'b1;
            ridx = ram_index_t'(rand_bits(8));
            if (!ram_v[ridx])
                ridx = idx;                         // Fall back to the fresh word
            bus_read(!m, ram_addr(ridx), rd);       // Other master reads
            check_data("read", ram_m[ridx], rd);
        end
        end_test();

        cur_test = "gpio";
        for (int i = 0; i < gpio_n_c; i++)
        begin
            m    = 1'(rand_bits(1));
            data = rand_bits(32);
            bus_write(m, {`AHB_GPIO_MATCH, 16'h0000}, data);
            gpio_m = data;
            bus_read(!m, {`AHB_GPIO_MATCH, 16'h0000}, rd);
            check_gpio("readback offset 0", gpio_m, rd);
            check_gpio("gpio_out pins", gpio_m, gpio_out);
        end
        @(negedge hclk);
        gpio_in = rand_bits(32);
        repeat (2) @(negedge hclk);                 // Two-stage input sync
        bus_read(1'b0, {`AHB_GPIO_MATCH, 16'h0004}, rd);
        check_gpio("gpio_in readback", gpio_in, rd);
        end_test();

        cur_test = "unmapped";
        for (int i = 0; i < err_n_c; i++)
        begin
            upper = 16'(rand_bits(16));
            if (upper < 16'd3)
                upper = upper + 16'd3;              // Outside all windows
            lo = 14'(rand_bits(14));
            m  = 1'(rand_bits(1));
            bus_xfer(m, 1'b0, {upper, lo, 2'b00}, '0, rd, rs, rdy1, rs1);
            check_bit("first cycle hready", 1'b0, rdy1);
            check_resp("first cycle response", ERROR, rs1);
            check_bit("second cycle hready", 1'b1, hready);
            check_resp("second cycle response", ERROR, rs);
            bus_read(!m, ram_addr(idx), rd);
            check_data("ram read after error", ram_m[idx], rd);
        end
        end_test();

        cur_test = "arbitration";
        for (int k = 0; k < 2; k++)
        begin
            for (int i = 0; i < arb_n_c; i++)
            begin
                arb_idx[k][i] = {7'(rand_bits(7)), k[0]};    // Parity splits the masters
                arb_dat[k][i] = rand_bits(32);
            end
        end
        accepted.delete();
        keep_req = 1'b1;
        fork
            arb_master(1'b0);
            arb_master(1'b1);
        join
        keep_req = 1'b0;
        @(negedge hclk);
        m_hbusreq = '0;
        for (int i = 1; i < accepted.size(); i++)
            check_bit("alternating owner", !accepted[i-1], accepted[i]);
        for (int k = 0; k < 2; k++)
        begin
            for (int i = 0; i < arb_n_c; i++)
            begin
                bus_read(!k[0], ram_addr(arb_idx[k][i]), rd);
                check_data("readback", ram_m[arb_idx[k][i]], rd);
            end
        end
        end_test();

        cur_test = "pwm";
        for (int r = 0; r < pwm_n_c; r++)
        begin
            duty_stg_m   = pwm_cnt_t'(rand_bits(`AHB_PWM_WIDTH));
            period_stg_m = pwm_cnt_t'(rand_bits(`AHB_PWM_WIDTH));
            bus_write(1'b0, {`AHB_PWM_MATCH, 16'h0004}, hdata_t'(duty_stg_m));
            bus_write(1'b1, {`AHB_PWM_MATCH, 16'h0000}, hdata_t'(period_stg_m));
            bus_read(1'b0, {`AHB_PWM_MATCH, 16'h0004}, rd);
            check_data("duty readback", hdata_t'(duty_stg_m), rd);
            bus_read(1'b1, {`AHB_PWM_MATCH, 16'h0000}, rd);
            check_data("period readback", hdata_t'(period_stg_m), rd);
            repeat ((1 << `AHB_PWM_WIDTH) + 2) @(negedge hclk);    // Past the next wrap
            period_act_m = period_stg_m;
            duty_act_m   = duty_stg_m;
            pp  = int'(period_act_m) + 1;           // Cycles per PWM period
            dd  = int'(duty_act_m);
            cnt = 0;
            for (int c = 0; c < 2*pp; c++)
            begin
                @(negedge hclk);
                if (pwm_out)
                    cnt++;
            end
            check_data("high cycles in two periods", hdata_t'(2 * ((dd < pp) ? dd : pp)),
                       hdata_t'(cnt));
        end
        end_test();

        $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : tb_ahb_subsys

//--- compile.f
+incdir+verilog
verilog/ahb_pkg.sv
verilog/periph_pkg.sv
verilog/ahb_if.sv
verilog/ahb_arbiter.sv
verilog/ahb_router.sv
verilog/ahb_ram.sv
verilog/ahb_gpio.sv
verilog/ahb_pwm.sv
verilog/ahb_subsys_top.sv
dv/tb_ahb_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build the AHB subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_ahb_subsys
./obj_dir/Vtb_ahb_subsys | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log
exit 0
